// ==== common/tile_cfg.svh ====
// Tile configuration macros shared by the package and the RTL
// The grid is square, so one size sets rows, columns and edge lanes
// TILE_CONST_WIDTH plus 4 opcode and side bits must fit in TILE_DATA_WIDTH
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Grid geometry
//////////////////////////////////////////////////////////////////////

// Rows, columns and lanes per edge side
`define TILE_GRID_SIZE 2

//////////////////////////////////////////////////////////////////////
// Token widths
//////////////////////////////////////////////////////////////////////

// Payload word carried by every forward token
`define TILE_DATA_WIDTH 32

// Constant held in a process element configuration
`define TILE_CONST_WIDTH 8

`endif

// ==== common/tile_pkg.sv ====
// Token and configuration types for the compute tile
// A payload word is read as data or as a config word, chosen by is_config
`include "tile_cfg.svh"

package tile_pkg;

	// Port and edge side index
	typedef enum logic [1:0] {
		side_north = 2'd0,
		side_east  = 2'd1,
		side_west  = 2'd2,
		side_south = 2'd3
	} side_t;

	// Process element operation
	typedef enum logic [1:0] {
		op_pass = 2'd0,
		op_add  = 2'd1,
		op_sub  = 2'd2,
		op_xor  = 2'd3
	} op_t;

	localparam int cfg_pad_width = `TILE_DATA_WIDTH - 4 - `TILE_CONST_WIDTH;

	// Config view of the payload, low bits unused
	typedef struct packed {
		op_t                          opcode;
		side_t                        out_side;
		logic [`TILE_CONST_WIDTH-1:0] constant;
		logic [cfg_pad_width-1:0]     unused;
	} pe_config_t;

	typedef union packed {
		logic [`TILE_DATA_WIDTH-1:0] data;
		pe_config_t                  cfg;
	} payload_t;

	// Forward token, hold runs against it as a plain level
	typedef struct packed {
		logic     valid;
		logic     is_config;
		side_t    dest;
		payload_t payload;
	} ftk_t;

	typedef ftk_t [3:0] ftk_side_t;
	typedef ftk_t [3:0][`TILE_GRID_SIZE-1:0] ftk_edge_t;

endpackage

// ==== route_element/route_element.sv ====
// Route element, forwards each token to the side named by its dest
// One register per output side; a register loads only when it starts empty
// Input priority is north, east, west, south
`timescale 1ns/100ps

module route_element
	import tile_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	input  ftk_side_t  in_tok,
	output logic [3:0] in_hold,
	output ftk_side_t  out_tok,
	input  logic [3:0] out_hold
);

	// Input granted into its target register this cycle
	logic [3:0] grant;
	// Output register handing its token downstream
	logic [3:0] drain;

	//////////////////////////////////////////////////////////////////////
	// Arbitration and hold
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		logic [3:0] claimed;
		claimed = '0;
		grant   = '0;
		for (int i = 0; i < 4; i++) begin
			// First valid input per dest side claims it
			if (in_tok[i].valid && !claimed[in_tok[i].dest]) begin
				claimed[in_tok[i].dest] = 1'b1;
				grant[i] = !out_tok[in_tok[i].dest].valid;
			end
		end
		// Losers and inputs facing a full register are held
		for (int i = 0; i < 4; i++) begin
			in_hold[i] = in_tok[i].valid && !grant[i];
		end
	end

	always_comb begin
		for (int s = 0; s < 4; s++) begin
			drain[s] = out_tok[s].valid && !out_hold[s];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int s = 0; s < 4; s++) begin
				out_tok[s].valid <= 1'b0;
			end
		end else begin
			for (int s = 0; s < 4; s++) begin
				if (drain[s]) begin
					out_tok[s].valid <= 1'b0;
				end
			end
			// Token passes unchanged, config tokens too
			for (int i = 0; i < 4; i++) begin
				if (grant[i]) begin
					out_tok[in_tok[i].dest] <= in_tok[i];
				end
			end
		end
	end

	// Held output keeps its token until the neighbour takes it
	for (genvar s = 0; s < 4; s++) begin : g_hold_check
		assert property (@(posedge clock) disable iff (!rst_n)
			out_tok[s].valid && out_hold[s] |=> $stable(out_tok[s]));
	end

endmodule

// ==== process_element/process_element.sv ====
// Process element with one output register shared by all four sides
// Config tokens load the configuration and produce no output
// Reset configuration is op_pass with out_side south and constant zero
`timescale 1ns/100ps
`include "tile_cfg.svh"

module process_element
	import tile_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	input  ftk_side_t  in_tok,
	output logic [3:0] in_hold,
	output ftk_side_t  out_tok,
	input  logic [3:0] out_hold
);

	pe_config_t                  cfg_q;
	ftk_t                        out_q;
	ftk_t                        sel_tok;
	logic                        take;
	logic [3:0]                  grant;
	logic [3:0]                  out_valid;
	logic [`TILE_DATA_WIDTH-1:0] operand;
	logic [`TILE_DATA_WIDTH-1:0] result;

	//////////////////////////////////////////////////////////////////////
	// Input selection
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		logic found;
		found   = 1'b0;
		grant   = '0;
		sel_tok = in_tok[side_north];
		for (int i = 0; i < 4; i++) begin
			if (in_tok[i].valid && !found) begin
				found    = 1'b1;
				grant[i] = !out_q.valid;
				sel_tok  = in_tok[i];
			end
		end
		take = found && !out_q.valid;
		for (int i = 0; i < 4; i++) begin
			in_hold[i] = in_tok[i].valid && !grant[i];
		end
	end

	// Constant is zero extended to the data width
	assign operand = {{(`TILE_DATA_WIDTH - `TILE_CONST_WIDTH){1'b0}}, cfg_q.constant};

	always_comb begin
		case (cfg_q.opcode)
			op_add:  result = sel_tok.payload.data + operand;
			op_sub:  result = sel_tok.payload.data - operand;
			op_xor:  result = sel_tok.payload.data ^ operand;
			default: result = sel_tok.payload.data;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Configuration and output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cfg_q       <= '{opcode: op_pass, out_side: side_south, default: '0};
			out_q.valid <= 1'b0;
		end else begin
			if (out_q.valid && !out_hold[out_q.dest]) begin
				out_q.valid <= 1'b0;
			end
			if (take) begin
				if (sel_tok.is_config) begin
					cfg_q <= sel_tok.payload.cfg;
				end else begin
					out_q.valid        <= 1'b1;
					out_q.is_config    <= 1'b0;
					out_q.dest         <= cfg_q.out_side;
					out_q.payload.data <= result;
				end
			end
		end
	end

	// Token shows only on its dest side
	always_comb begin
		for (int s = 0; s < 4; s++) begin
			out_valid[s]     = out_q.valid && (out_q.dest == side_t'(s));
			out_tok[s]       = out_q;
			out_tok[s].valid = out_valid[s];
		end
	end

	// No config can land while a result waits, so dest tracks out_side
	assert property (@(posedge clock) disable iff (!rst_n)
		out_q.valid |-> (out_q.dest == cfg_q.out_side));

endmodule

// ==== logic/compute_tile.sv ====
// Square checkerboard of route and process elements
// Even row plus column holds a route element, odd holds a process element
// North and south lanes follow the column, east and west lanes the row
`timescale 1ns/100ps
`include "tile_cfg.svh"

module compute_tile
	import tile_pkg::*;
(
	input  logic                            clock,
	input  logic                            rst_n,
	input  ftk_edge_t                       edge_in,
	output logic [3:0][`TILE_GRID_SIZE-1:0] edge_hold_out,
	output ftk_edge_t                       edge_out,
	input  logic [3:0][`TILE_GRID_SIZE-1:0] edge_hold_in
);

	// Per element ports, indexed [row][column]
	ftk_side_t  el_in       [`TILE_GRID_SIZE][`TILE_GRID_SIZE];
	ftk_side_t  el_out      [`TILE_GRID_SIZE][`TILE_GRID_SIZE];
	logic [3:0] el_in_hold  [`TILE_GRID_SIZE][`TILE_GRID_SIZE];
	logic [3:0] el_out_hold [`TILE_GRID_SIZE][`TILE_GRID_SIZE];

	for (genvar r = 0; r < `TILE_GRID_SIZE; r++) begin : g_row
		for (genvar c = 0; c < `TILE_GRID_SIZE; c++) begin : g_col

			//////////////////////////////////////////////////////////////////////
			// Side inputs, from a neighbour or from the edge
			//////////////////////////////////////////////////////////////////////

			if (r == 0) begin : g_north_edge
				assign el_in[r][c][side_north]       = edge_in[side_north][c];
				assign el_out_hold[r][c][side_north] = edge_hold_in[side_north][c];
				assign edge_out[side_north][c]       = el_out[r][c][side_north];
				assign edge_hold_out[side_north][c]  = el_in_hold[r][c][side_north];
			end else begin : g_north_mesh
				assign el_in[r][c][side_north]       = el_out[r-1][c][side_south];
				assign el_out_hold[r][c][side_north] = el_in_hold[r-1][c][side_south];
			end

			if (r == `TILE_GRID_SIZE - 1) begin : g_south_edge
				assign el_in[r][c][side_south]       = edge_in[side_south][c];
				assign el_out_hold[r][c][side_south] = edge_hold_in[side_south][c];
				assign edge_out[side_south][c]       = el_out[r][c][side_south];
				assign edge_hold_out[side_south][c]  = el_in_hold[r][c][side_south];
			end else begin : g_south_mesh
				assign el_in[r][c][side_south]       = el_out[r+1][c][side_north];
				assign el_out_hold[r][c][side_south] = el_in_hold[r+1][c][side_north];
			end

			if (c == 0) begin : g_west_edge
				assign el_in[r][c][side_west]       = edge_in[side_west][r];
				assign el_out_hold[r][c][side_west] = edge_hold_in[side_west][r];
				assign edge_out[side_west][r]       = el_out[r][c][side_west];
				assign edge_hold_out[side_west][r]  = el_in_hold[r][c][side_west];
			end else begin : g_west_mesh
				assign el_in[r][c][side_west]       = el_out[r][c-1][side_east];
				assign el_out_hold[r][c][side_west] = el_in_hold[r][c-1][side_east];
			end

			if (c == `TILE_GRID_SIZE - 1) begin : g_east_edge
				assign el_in[r][c][side_east]       = edge_in[side_east][r];
				assign el_out_hold[r][c][side_east] = edge_hold_in[side_east][r];
				assign edge_out[side_east][r]       = el_out[r][c][side_east];
				assign edge_hold_out[side_east][r]  = el_in_hold[r][c][side_east];
			end else begin : g_east_mesh
				assign el_in[r][c][side_east]       = el_out[r][c+1][side_west];
				assign el_out_hold[r][c][side_east] = el_in_hold[r][c+1][side_west];
			end

			//////////////////////////////////////////////////////////////////////
			// Element placement
			//////////////////////////////////////////////////////////////////////

			if (((r + c) % 2) == 0) begin : g_re
				route_element route_element_inst (
					.clock    (clock),
					.rst_n    (rst_n),
					.in_tok   (el_in[r][c]),
					.in_hold  (el_in_hold[r][c]),
					.out_tok  (el_out[r][c]),
					.out_hold (el_out_hold[r][c])
				);
			end else begin : g_pe
				process_element process_element_inst (
					.clock    (clock),
					.rst_n    (rst_n),
					.in_tok   (el_in[r][c]),
					.in_hold  (el_in_hold[r][c]),
					.out_tok  (el_out[r][c]),
					.out_hold (el_out_hold[r][c])
				);
			end
		end
	end

endmodule

// ==== testbench/tb_compute_tile.sv ====
// Testbench for the compute tile, written for the default 2 by 2 grid
// Outputs and holds are sampled 1 ns after the falling edge, where they are stable
`timescale 1ns/100ps
`include "tile_cfg.svh"

module tb_compute_tile
	import tile_pkg::*;
();

	localparam int N       = `TILE_GRID_SIZE;
	localparam int DW      = `TILE_DATA_WIDTH;
	localparam int CW      = `TILE_CONST_WIDTH;
	localparam int TIMEOUT = 200;

	// Where a token is expected to leave the tile
	typedef struct packed {
		side_t side;
		int    lane;
		ftk_t  tok;
	} exit_t;

	logic              clock;
	logic              rst_n;
	ftk_edge_t         edge_in;
	logic [3:0][N-1:0] edge_hold_out;
	ftk_edge_t         edge_out;
	logic [3:0][N-1:0] edge_hold_in;

	pe_config_t ref_cfg [N][N];
	exit_t      expect_q [$];
	int         checks   = 0;
	int         errors   = 0;
	int         timeouts = 0;

	compute_tile compute_tile_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.edge_in       (edge_in),
		.edge_hold_out (edge_hold_out),
		.edge_out      (edge_out),
		.edge_hold_in  (edge_hold_in)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Walks a token through the checkerboard, a config token stops at its process element
	function automatic exit_t ref_walk(input side_t in_side, input int lane, input ftk_t tok);
		exit_t         res;
		side_t         go;
		int            r;
		int            c;
		logic [DW-1:0] k;
		res = '0;
		r = (in_side == side_south) ? N - 1 : ((in_side == side_north) ? 0 : lane);
		c = (in_side == side_east) ? N - 1 : ((in_side == side_west) ? 0 : lane);
		for (int step = 0; step < 4 * N * N; step++) begin
			if ((r + c) % 2 == 1) begin
				if (tok.is_config) begin
					ref_cfg[r][c] = tok.payload.cfg;
					return res;
				end
				k = {{(DW - CW){1'b0}}, ref_cfg[r][c].constant};
				case (ref_cfg[r][c].opcode)
					op_add:  tok.payload.data = tok.payload.data + k;
					op_sub:  tok.payload.data = tok.payload.data - k;
					op_xor:  tok.payload.data = tok.payload.data ^ k;
					default: tok.payload.data = tok.payload.data;
				endcase
				tok.dest = ref_cfg[r][c].out_side;
			end
			go = tok.dest;
			if ((go == side_north && r == 0) || (go == side_south && r == N - 1)
					|| (go == side_west && c == 0) || (go == side_east && c == N - 1)) begin
				res.side = go;
				res.lane = (go == side_north || go == side_south) ? c : r;
				res.tok  = tok;
				return res;
			end
			case (go)
				side_north: r = r - 1;
				side_south: r = r + 1;
				side_west:  c = c - 1;
				default:    c = c + 1;
			endcase
		end
		return res;
	endfunction

	function automatic ftk_t make_token(input logic is_cfg, input side_t dest,
			input logic [DW-1:0] word);
		ftk_t t;
		t.valid        = 1'b1;
		t.is_config    = is_cfg;
		t.dest         = dest;
		t.payload.data = word;
		return t;
	endfunction

	task automatic predict(input side_t in_side, input int lane, input ftk_t tok);
		exit_t e;
		e = ref_walk(in_side, lane, tok);
		if (e.tok.valid) begin
			expect_q.push_back(e);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Second token is skipped when its valid is low
	task automatic send_tokens(input side_t sa, input int la, input ftk_t ta,
			input side_t sb, input int lb, input ftk_t tb);
		logic done_a;
		logic done_b;
		logic take_a;
		logic take_b;
		int   cycles;
		done_a = 1'b0;
		done_b = !tb.valid;
		cycles = 0;
		@(negedge clock);
		edge_in[sa][la] = ta;
		if (tb.valid) begin
			edge_in[sb][lb] = tb;
		end
		while (!(done_a && done_b) && cycles < TIMEOUT) begin
			#1;
			take_a = !done_a && !edge_hold_out[sa][la];
			take_b = !done_b && !edge_hold_out[sb][lb];
			@(negedge clock);
			if (take_a) begin
				edge_in[sa][la].valid = 1'b0;
				done_a = 1'b1;
			end
			if (take_b) begin
				edge_in[sb][lb].valid = 1'b0;
				done_b = 1'b1;
			end
			cycles++;
		end
		if (!(done_a && done_b)) begin
			timeouts++;
			$display("Timed out at %0t, a token on edge_in was never accepted", $time);
			edge_in[sa][la].valid = 1'b0;
			edge_in[sb][lb].valid = 1'b0;
		end
	endtask

	// A few idle cycles at the end catch duplicated tokens
	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0 && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (expect_q.size() != 0) begin
			timeouts++;
			$display("Timed out waiting for %s, %0d tokens never left", what, expect_q.size());
			expect_q.delete();
		end
		repeat (4) @(negedge clock);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparison of every token that leaves the tile
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		exit_t exp_e;
		#1;
		for (int s = 0; s < 4; s++) begin
			for (int l = 0; l < N; l++) begin
				if (rst_n && edge_out[s][l].valid && !edge_hold_in[s][l]) begin
					checks++;
					if (expect_q.size() == 0) begin
						errors++;
						$display("Unexpected token %h left side %0d lane %0d at %0t",
							edge_out[s][l], s, l, $time);
					end else begin
						exp_e = expect_q.pop_front();
						if (int'(exp_e.side) != s || exp_e.lane != l) begin
							errors++;
							$display("error at %0t: edge_out exit expected %0d/%0d, got %0d/%0d",
								$time, exp_e.side, exp_e.lane, s, l);
						end else if (edge_out[s][l] !== exp_e.tok) begin
							errors++;
							$display("error at %0t: edge_out[%0d][%0d] expected %h, got %h",
								$time, s, l, exp_e.tok, edge_out[s][l]);
						end
					end
				end
			end
		end
	end

	initial begin
		ftk_t       tok;
		ftk_t       tok_b;
		ftk_t       held;
		pe_config_t cfg;
		logic       top;
		side_t      in_side;
		int         in_lane;
		int         cycles;
		void'($urandom(32'h4944d46c));
		rst_n        = 1'b0;
		edge_in      = '0;
		edge_hold_in = '0;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				ref_cfg[r][c] = '{opcode: op_pass, out_side: side_south, default: '0};
			end
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// Idle tile after reset
		@(negedge clock);
		#1;
		for (int s = 0; s < 4; s++) begin
			for (int l = 0; l < N; l++) begin
				checks++;
				if (edge_out[s][l].valid !== 1'b0 || edge_hold_out[s][l] !== 1'b0) begin
					errors++;
					$display("error at %0t: edge_out[%0d][%0d] valid/hold expected 0/0, got %b/%b",
						$time, s, l, edge_out[s][l].valid, edge_hold_out[s][l]);
				end
			end
		end

		// Route (0,0) turns a north token straight out of west lane 0
		tok = make_token(1'b0, side_west, DW'($urandom()));
		predict(side_north, 0, tok);
		send_tokens(side_north, 0, tok, side_north, 0, '0);
		wait_drained("the west exit");

		// Config for process (0,1), then one data token through it
		cfg = '{opcode: op_add, out_side: side_east, constant: CW'($urandom()), unused: '0};
		tok = make_token(1'b1, side_east, cfg);
		predict(side_north, 0, tok);
		send_tokens(side_north, 0, tok, side_north, 0, '0);
		wait_drained("the config token");
		tok = make_token(1'b0, side_east, DW'($urandom()));
		predict(side_north, 0, tok);
		send_tokens(side_north, 0, tok, side_north, 0, '0);
		wait_drained("the add result");

		// Back-pressure on east lane 0
		@(negedge clock);
		edge_hold_in[side_east][0] = 1'b1;
		tok = make_token(1'b0, side_east, DW'($urandom()));
		predict(side_north, 0, tok);
		send_tokens(side_north, 0, tok, side_north, 0, '0);
		cycles = 0;
		#1;
		while (!edge_out[side_east][0].valid && cycles < TIMEOUT) begin
			@(negedge clock);
			#1;
			cycles++;
		end
		if (!edge_out[side_east][0].valid) begin
			timeouts++;
			$display("Timed out waiting for the held token on east lane 0");
		end else begin
			held = edge_out[side_east][0];
			repeat (5) begin
				@(negedge clock);
				#1;
				checks++;
				if (edge_out[side_east][0] !== held) begin
					errors++;
					$display("error at %0t: edge_out[1][0] expected %h, got %h",
						$time, held, edge_out[side_east][0]);
				end
			end
		end
		@(negedge clock);
		edge_hold_in[side_east][0] = 1'b0;
		wait_drained("the released token");

		// Route, process, route with random opcodes
		for (int i = 0; i < 6; i++) begin
			top     = ($urandom() % 2) != 0;
			in_side = top ? side_north : side_east;
			in_lane = top ? 0 : 1;
			cfg = '{opcode: op_t'(2'($urandom())), out_side: top ? side_south : side_north,
				constant: CW'($urandom()), unused: '0};
			tok = make_token(1'b1, top ? side_east : side_west, cfg);
			predict(in_side, in_lane, tok);
			send_tokens(in_side, in_lane, tok, side_north, 0, '0);
			for (int j = 0; j < 3; j++) begin
				tok = make_token(1'b0, top ? side_east : side_west, DW'($urandom()));
				predict(in_side, in_lane, tok);
				send_tokens(in_side, in_lane, tok, side_north, 0, '0);
				wait_drained("a multi-hop token");
			end
		end

		// East input beats south input at route (1,1)
		tok   = make_token(1'b0, side_east, DW'($urandom()));
		tok_b = make_token(1'b0, side_east, DW'($urandom()));
		predict(side_east, 1, tok);
		predict(side_south, 1, tok_b);
		send_tokens(side_east, 1, tok, side_south, 1, tok_b);
		wait_drained("the two east tokens");

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== compute_tile.f ====
+incdir+common
common/tile_pkg.sv
route_element/route_element.sv
process_element/process_element.sv
logic/compute_tile.sv
testbench/tb_compute_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the compute tile testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f compute_tile.f \
	--top-module tb_compute_tile > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_compute_tile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
